//--- rtl/core_pkg.sv
`default_nettype none

package core_pkg;

  typedef logic [31:0] word_t;       // Data and address word
  typedef logic [4:0]  reg_addr_t;
  typedef logic [1:0]  fwd_sel_t;    // EX operand source
  typedef logic [1:0]  result_src_t;

  // Writeback source
  localparam result_src_t RESULT_SRC_SELECT_ALU          = 2'b00;
  localparam result_src_t RESULT_SRC_SELECT_DMEM_RD_DATA = 2'b01;

  // Youngest producer carries the highest code
  localparam fwd_sel_t FWD_NONE = 2'b00;
  localparam fwd_sel_t FWD_WB   = 2'b01;
  localparam fwd_sel_t FWD_MEM2 = 2'b10;
  localparam fwd_sel_t FWD_MEM1 = 2'b11;

  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;

  localparam logic [2:0] F3_ADD  = 3'b000;  // Shared by ADDI and BEQ
  localparam logic [2:0] F3_WORD = 3'b010;  // LW and SW
  localparam logic [6:0] F7_ADD  = 7'b0000000;

  localparam word_t RESET_PC    = 32'h0000_0000;
  localparam word_t TRAP_VECTOR = 32'h0000_0200;

endpackage

`default_nettype wire

//--- rtl/hazard_unit.sv
`timescale 1ns/1ps
`default_nettype none

module hazard_unit (
  input  core_pkg::reg_addr_t   ex_rs1_addr_i,
  input  core_pkg::reg_addr_t   ex_rs2_addr_i,
  input  core_pkg::reg_addr_t   mem1_rd_addr_i,
  input  core_pkg::reg_addr_t   mem2_rd_addr_i,
  input  core_pkg::reg_addr_t   wb_rd_addr_i,
  input  core_pkg::reg_addr_t   id_rs1_addr_i,
  input  core_pkg::reg_addr_t   id_rs2_addr_i,
  input  core_pkg::reg_addr_t   ex_rd_addr_i,
  input  core_pkg::result_src_t ex_result_src_i,
  input  logic                  ex_pc_src_i,
  input  logic                  id_trap_valid_i,
  input  logic                  ex_trap_valid_i,
  input  logic                  mem1_trap_valid_i,
  input  logic                  mem2_trap_valid_i,
  input  logic                  wb_trap_valid_i,
  output core_pkg::fwd_sel_t    ex_forward_a_o,
  output core_pkg::fwd_sel_t    ex_forward_b_o,
  output logic                  id_forward_a_o,
  output logic                  id_forward_b_o,
  output logic                  id_flush_o,
  output logic                  ex_flush_o,
  output logic                  mem1_flush_o,
  output logic                  mem2_flush_o,
  output logic                  wb_flush_o,
  output logic                  if_stall_o,
  output logic                  id_stall_o
);
  import core_pkg::*;

  logic load_use_stall;
  logic trap_past_id;  // Trap anywhere from EX to WB

  // Youngest matching producer wins
  function automatic fwd_sel_t pick_fwd(input reg_addr_t rs, input reg_addr_t mem1_rd,
                                        input reg_addr_t mem2_rd, input reg_addr_t wb_rd);
    fwd_sel_t sel;
    sel = FWD_NONE;
    if (rs != '0) begin
      if (rs == mem1_rd) sel = FWD_MEM1;
      else if (rs == mem2_rd) sel = FWD_MEM2;
      else if (rs == wb_rd) sel = FWD_WB;
    end
    return sel;
  endfunction

  assign ex_forward_a_o = pick_fwd(ex_rs1_addr_i, mem1_rd_addr_i, mem2_rd_addr_i, wb_rd_addr_i);
  assign ex_forward_b_o = pick_fwd(ex_rs2_addr_i, mem1_rd_addr_i, mem2_rd_addr_i, wb_rd_addr_i);

  // WB writes the register file in the same cycle ID reads it
  assign id_forward_a_o = (id_rs1_addr_i != '0) && (id_rs1_addr_i == wb_rd_addr_i);
  assign id_forward_b_o = (id_rs2_addr_i != '0) && (id_rs2_addr_i == wb_rd_addr_i);

  // Load data only exists from MEM1 on
  assign load_use_stall = (ex_result_src_i == RESULT_SRC_SELECT_DMEM_RD_DATA) &&
                          (ex_rd_addr_i != '0) &&
                          ((id_rs1_addr_i == ex_rd_addr_i) || (id_rs2_addr_i == ex_rd_addr_i));

  assign trap_past_id = ex_trap_valid_i | mem1_trap_valid_i | mem2_trap_valid_i | wb_trap_valid_i;

  assign id_flush_o   = ex_pc_src_i | (id_trap_valid_i & ~load_use_stall) | trap_past_id;
  assign ex_flush_o   = ex_pc_src_i | load_use_stall | trap_past_id;  // Bubble on load-use
  assign mem1_flush_o = mem1_trap_valid_i | mem2_trap_valid_i | wb_trap_valid_i;
  assign mem2_flush_o = mem2_trap_valid_i | wb_trap_valid_i;
  assign wb_flush_o   = wb_trap_valid_i;

  assign if_stall_o = load_use_stall;
  assign id_stall_o = load_use_stall;

endmodule

`default_nettype wire

//--- rtl/fetch_stage.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_stage (
  input  logic            clk_i,
  input  logic            reset_i,
  input  logic            stall_i,
  input  logic            flush_i,
  input  logic            branch_taken_i,
  input  core_pkg::word_t branch_target_i,
  input  logic            trap_redirect_i,
  input  core_pkg::word_t imem_data_i,
  output core_pkg::word_t imem_addr_o,
  output core_pkg::word_t id_instr_o,
  output core_pkg::word_t id_pc_o,
  output logic            id_valid_o
);
  import core_pkg::*;

  word_t pc_q;
  word_t pc_next;

  always_comb begin
    if (trap_redirect_i) pc_next = TRAP_VECTOR;  // WB trap beats everything
    else if (branch_taken_i) pc_next = branch_target_i;
    else if (stall_i) pc_next = pc_q;
    else pc_next = pc_q + 32'd4;
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) pc_q <= RESET_PC;
    else pc_q <= pc_next;
  end

  assign imem_addr_o = pc_q;

  // A flush of the IF/ID register overrides the hold
  always_ff @(posedge clk_i) begin
    if (reset_i || flush_i) id_valid_o <= 1'b0;
    else if (!stall_i) id_valid_o <= 1'b1;
  end

  always_ff @(posedge clk_i) begin
    if (!stall_i) begin
      id_instr_o <= imem_data_i;
      id_pc_o    <= pc_q;
    end
  end

endmodule

`default_nettype wire

//--- rtl/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file (
  input  logic                clk_i,
  input  core_pkg::reg_addr_t rs1_addr_i,
  input  core_pkg::reg_addr_t rs2_addr_i,
  input  core_pkg::reg_addr_t rd_addr_i,
  input  logic                we_i,
  input  core_pkg::word_t     rd_data_i,
  output core_pkg::word_t     rs1_data_o,
  output core_pkg::word_t     rs2_data_o
);
  import core_pkg::*;

  word_t regs [0:31];

  // All registers start at zero
  initial begin
    for (int i = 0; i < 32; i++) begin
      regs[i] = '0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (we_i && (rd_addr_i != '0)) begin  // x0 stays zero
      regs[rd_addr_i] <= rd_data_i;
    end
  end

  assign rs1_data_o = regs[rs1_addr_i];
  assign rs2_data_o = regs[rs2_addr_i];

endmodule

`default_nettype wire

//--- rtl/decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

module decode_stage (
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  logic                  stall_i,
  input  logic                  flush_i,
  input  core_pkg::word_t       instr_i,
  input  core_pkg::word_t       pc_i,
  input  logic                  valid_i,
  input  core_pkg::word_t       rs1_data_i,
  input  core_pkg::word_t       rs2_data_i,
  input  logic                  forward_a_i,
  input  logic                  forward_b_i,
  input  core_pkg::word_t       wb_data_i,
  output core_pkg::reg_addr_t   id_rs1_addr_o,
  output core_pkg::reg_addr_t   id_rs2_addr_o,
  output logic                  id_trap_o,
  output core_pkg::word_t       ex_pc_o,
  output core_pkg::reg_addr_t   ex_rs1_addr_o,
  output core_pkg::reg_addr_t   ex_rs2_addr_o,
  output core_pkg::reg_addr_t   ex_rd_addr_o,
  output core_pkg::word_t       ex_op_a_o,
  output core_pkg::word_t       ex_op_b_o,
  output core_pkg::word_t       ex_imm_o,
  output logic                  ex_alu_imm_o,
  output core_pkg::result_src_t ex_result_src_o,
  output logic                  ex_reg_write_o,
  output logic                  ex_mem_write_o,
  output logic                  ex_branch_o,
  output logic                  ex_trap_o,
  output logic                  ex_valid_o
);
  import core_pkg::*;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic       is_add, is_addi, is_lw, is_sw, is_beq;
  logic       legal;
  logic       writes_rd;
  word_t      imm;

  assign opcode = instr_i[6:0];
  assign funct3 = instr_i[14:12];
  assign funct7 = instr_i[31:25];

  assign is_add  = (opcode == OPC_OP) && (funct3 == F3_ADD) && (funct7 == F7_ADD);
  assign is_addi = (opcode == OPC_OP_IMM) && (funct3 == F3_ADD);
  assign is_lw   = (opcode == OPC_LOAD) && (funct3 == F3_WORD);
  assign is_sw   = (opcode == OPC_STORE) && (funct3 == F3_WORD);
  assign is_beq  = (opcode == OPC_BRANCH) && (funct3 == F3_ADD);

  assign legal     = is_add | is_addi | is_lw | is_sw | is_beq;
  assign id_trap_o = valid_i & ~legal;
  assign writes_rd = valid_i & (is_add | is_addi | is_lw);

  // Unused operand fields read as x0 so they cause no false stall
  assign id_rs1_addr_o = (valid_i && legal) ? instr_i[19:15] : '0;
  assign id_rs2_addr_o = (valid_i && (is_add || is_sw || is_beq)) ? instr_i[24:20] : '0;

  always_comb begin
    if (is_sw) imm = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
    else if (is_beq) imm = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                            instr_i[11:8], 1'b0};
    else imm = {{20{instr_i[31]}}, instr_i[31:20]};  // I-type
  end

  // A stall leaves a bubble in the ID/EX control
  always_ff @(posedge clk_i) begin
    if (reset_i || flush_i || stall_i) begin
      ex_valid_o      <= 1'b0;
      ex_trap_o       <= 1'b0;
      ex_reg_write_o  <= 1'b0;
      ex_mem_write_o  <= 1'b0;
      ex_branch_o     <= 1'b0;
      ex_result_src_o <= RESULT_SRC_SELECT_ALU;
      ex_rd_addr_o    <= '0;
      ex_rs1_addr_o   <= '0;
      ex_rs2_addr_o   <= '0;
    end else begin
      ex_valid_o      <= valid_i;
      ex_trap_o       <= id_trap_o;
      ex_reg_write_o  <= writes_rd;
      ex_mem_write_o  <= valid_i & is_sw;
      ex_branch_o     <= valid_i & is_beq;
      ex_result_src_o <= is_lw ? RESULT_SRC_SELECT_DMEM_RD_DATA : RESULT_SRC_SELECT_ALU;
      ex_rd_addr_o    <= writes_rd ? instr_i[11:7] : '0;
      ex_rs1_addr_o   <= id_rs1_addr_o;
      ex_rs2_addr_o   <= id_rs2_addr_o;
    end
  end

  always_ff @(posedge clk_i) begin
    ex_pc_o      <= pc_i;
    ex_op_a_o    <= forward_a_i ? wb_data_i : rs1_data_i;  // WB write in flight
    ex_op_b_o    <= forward_b_i ? wb_data_i : rs2_data_i;
    ex_imm_o     <= imm;
    ex_alu_imm_o <= is_addi | is_lw | is_sw;
  end

endmodule

`default_nettype wire

//--- rtl/execute_stage.sv
`timescale 1ns/1ps
`default_nettype none

module execute_stage (
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  logic                  flush_i,
  input  core_pkg::word_t       ex_pc_i,
  input  core_pkg::reg_addr_t   ex_rd_addr_i,
  input  core_pkg::word_t       ex_op_a_i,
  input  core_pkg::word_t       ex_op_b_i,
  input  core_pkg::word_t       ex_imm_i,
  input  logic                  ex_alu_imm_i,
  input  core_pkg::result_src_t ex_result_src_i,
  input  logic                  ex_reg_write_i,
  input  logic                  ex_mem_write_i,
  input  logic                  ex_branch_i,
  input  logic                  ex_trap_i,
  input  logic                  ex_valid_i,
  input  core_pkg::fwd_sel_t    forward_a_i,
  input  core_pkg::fwd_sel_t    forward_b_i,
  input  core_pkg::word_t       mem1_result_i,
  input  core_pkg::word_t       mem2_result_i,
  input  core_pkg::word_t       wb_result_i,
  output logic                  pc_src_o,
  output core_pkg::word_t       branch_target_o,
  output core_pkg::word_t       mem1_pc_o,
  output core_pkg::word_t       mem1_alu_o,
  output core_pkg::word_t       mem1_store_data_o,
  output core_pkg::reg_addr_t   mem1_rd_addr_o,
  output core_pkg::result_src_t mem1_result_src_o,
  output logic                  mem1_reg_write_o,
  output logic                  mem1_mem_write_o,
  output logic                  mem1_trap_o,
  output logic                  mem1_valid_o
);
  import core_pkg::*;

  word_t op_a;
  word_t op_b;
  word_t alu_result;

  function automatic word_t fwd_mux(input fwd_sel_t sel, input word_t id_val,
                                    input word_t mem1, input word_t mem2, input word_t wb);
    case (sel)
      FWD_MEM1: return mem1;
      FWD_MEM2: return mem2;
      FWD_WB:   return wb;
      default:  return id_val;
    endcase
  endfunction

  assign op_a = fwd_mux(forward_a_i, ex_op_a_i, mem1_result_i, mem2_result_i, wb_result_i);
  assign op_b = fwd_mux(forward_b_i, ex_op_b_i, mem1_result_i, mem2_result_i, wb_result_i);

  // Same adder for ADD, ADDI and load/store addresses
  assign alu_result = op_a + (ex_alu_imm_i ? ex_imm_i : op_b);

  assign pc_src_o        = ex_valid_i && ex_branch_i && (op_a == op_b);
  assign branch_target_o = ex_pc_i + ex_imm_i;

  always_ff @(posedge clk_i) begin
    if (reset_i || flush_i) begin
      mem1_valid_o      <= 1'b0;
      mem1_trap_o       <= 1'b0;
      mem1_reg_write_o  <= 1'b0;
      mem1_mem_write_o  <= 1'b0;
      mem1_result_src_o <= RESULT_SRC_SELECT_ALU;
      mem1_rd_addr_o    <= '0;
    end else begin
      mem1_valid_o      <= ex_valid_i;
      mem1_trap_o       <= ex_trap_i;
      mem1_reg_write_o  <= ex_reg_write_i;
      mem1_mem_write_o  <= ex_mem_write_i;
      mem1_result_src_o <= ex_result_src_i;
      mem1_rd_addr_o    <= ex_rd_addr_i;
    end
  end

  always_ff @(posedge clk_i) begin
    mem1_pc_o         <= ex_pc_i;
    mem1_alu_o        <= alu_result;
    mem1_store_data_o <= op_b;  // Forwarded rs2
  end

endmodule

`default_nettype wire

//--- rtl/memory_writeback.sv
`timescale 1ns/1ps
`default_nettype none

module memory_writeback (
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  logic                  mem1_flush_i,
  input  logic                  mem2_flush_i,
  input  logic                  wb_flush_i,
  input  core_pkg::word_t       mem1_pc_i,
  input  core_pkg::word_t       mem1_alu_i,
  input  core_pkg::word_t       mem1_store_data_i,
  input  core_pkg::reg_addr_t   mem1_rd_addr_i,
  input  core_pkg::result_src_t mem1_result_src_i,
  input  logic                  mem1_reg_write_i,
  input  logic                  mem1_mem_write_i,
  input  logic                  mem1_trap_i,
  input  logic                  mem1_valid_i,
  input  core_pkg::word_t       dmem_rdata_i,
  output core_pkg::word_t       dmem_addr_o,
  output core_pkg::word_t       dmem_wdata_o,
  output logic                  dmem_we_o,
  output core_pkg::word_t       mem1_result_o,
  output core_pkg::word_t       mem2_result_o,
  output core_pkg::reg_addr_t   mem2_rd_addr_o,
  output core_pkg::word_t       wb_result_o,
  output core_pkg::reg_addr_t   wb_rd_addr_o,
  output logic                  mem2_trap_o,
  output logic                  wb_trap_o,
  output logic                  wb_reg_write_o,
  output logic                  retire_valid_o,
  output core_pkg::word_t       retire_pc_o,
  output logic                  retire_trap_o,
  output core_pkg::reg_addr_t   retire_rd_o,
  output core_pkg::word_t       retire_data_o
);
  import core_pkg::*;

  logic  mem2_valid;
  logic  mem2_reg_write;
  word_t mem2_pc;
  logic  wb_valid;
  word_t wb_pc;

  assign dmem_addr_o  = mem1_alu_i;
  assign dmem_wdata_o = mem1_store_data_i;
  // A trap here or further down kills the store
  assign dmem_we_o    = mem1_valid_i & mem1_mem_write_i & ~mem1_flush_i;

  assign mem1_result_o = (mem1_result_src_i == RESULT_SRC_SELECT_DMEM_RD_DATA) ?
                         dmem_rdata_i : mem1_alu_i;

  always_ff @(posedge clk_i) begin
    if (reset_i || mem2_flush_i) begin
      mem2_valid     <= 1'b0;
      mem2_trap_o    <= 1'b0;
      mem2_reg_write <= 1'b0;
      mem2_rd_addr_o <= '0;
    end else begin
      mem2_valid     <= mem1_valid_i;
      mem2_trap_o    <= mem1_trap_i;
      mem2_reg_write <= mem1_reg_write_i;
      mem2_rd_addr_o <= mem1_rd_addr_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i || wb_flush_i) begin
      wb_valid       <= 1'b0;
      wb_trap_o      <= 1'b0;
      wb_reg_write_o <= 1'b0;
      wb_rd_addr_o   <= '0;
    end else begin
      wb_valid       <= mem2_valid;
      wb_trap_o      <= mem2_trap_o;
      wb_reg_write_o <= mem2_reg_write;
      wb_rd_addr_o   <= mem2_rd_addr_o;
    end
  end

  always_ff @(posedge clk_i) begin
    mem2_pc       <= mem1_pc_i;
    mem2_result_o <= mem1_result_o;
    wb_pc         <= mem2_pc;
    wb_result_o   <= mem2_result_o;
  end

  assign retire_valid_o = wb_valid;
  assign retire_pc_o    = wb_pc;
  assign retire_trap_o  = wb_trap_o;
  assign retire_rd_o    = wb_rd_addr_o;
  assign retire_data_o  = wb_reg_write_o ? wb_result_o : '0;  // Zero when nothing written

endmodule

`default_nettype wire

//--- rtl/pipeline_core.sv
`timescale 1ns/1ps
`default_nettype none

module pipeline_core (
  input  logic                clk_i,
  input  logic                reset_i,
  output core_pkg::word_t     imem_addr_o,
  input  core_pkg::word_t     imem_data_i,
  output core_pkg::word_t     dmem_addr_o,
  output core_pkg::word_t     dmem_wdata_o,
  output logic                dmem_we_o,
  input  core_pkg::word_t     dmem_rdata_i,
  output logic                retire_valid_o,
  output core_pkg::word_t     retire_pc_o,
  output logic                retire_trap_o,
  output core_pkg::reg_addr_t retire_rd_o,
  output core_pkg::word_t     retire_data_o
);
  import core_pkg::*;

  word_t       id_instr, id_pc;
  logic        id_valid, id_trap;
  reg_addr_t   id_rs1_addr, id_rs2_addr;
  word_t       rs1_data, rs2_data;
  word_t       ex_pc, ex_op_a, ex_op_b, ex_imm;
  reg_addr_t   ex_rs1_addr, ex_rs2_addr, ex_rd_addr;
  result_src_t ex_result_src;
  logic        ex_alu_imm, ex_reg_write, ex_mem_write, ex_branch, ex_trap, ex_valid;
  logic        pc_src;
  word_t       branch_target;
  word_t       mem1_pc, mem1_alu, mem1_store_data, mem1_result;
  reg_addr_t   mem1_rd_addr;
  result_src_t mem1_result_src;
  logic        mem1_reg_write, mem1_mem_write, mem1_trap, mem1_valid;
  word_t       mem2_result, wb_result;
  reg_addr_t   mem2_rd_addr, wb_rd_addr;
  logic        mem2_trap, wb_trap, wb_reg_write;
  fwd_sel_t    ex_forward_a, ex_forward_b;
  logic        id_forward_a, id_forward_b;
  logic        id_flush, ex_flush, mem1_flush, mem2_flush, wb_flush;
  logic        if_stall, id_stall;

  fetch_stage u_fetch (
    .clk_i(clk_i), .reset_i(reset_i), .stall_i(if_stall), .flush_i(id_flush),
    .branch_taken_i(pc_src), .branch_target_i(branch_target),
    .trap_redirect_i(wb_trap),  // Trap commits in WB
    .imem_data_i(imem_data_i), .imem_addr_o(imem_addr_o),
    .id_instr_o(id_instr), .id_pc_o(id_pc), .id_valid_o(id_valid)
  );

  reg_file u_regs (
    .clk_i(clk_i), .rs1_addr_i(id_rs1_addr), .rs2_addr_i(id_rs2_addr),
    .rd_addr_i(wb_rd_addr), .we_i(wb_reg_write), .rd_data_i(wb_result),
    .rs1_data_o(rs1_data), .rs2_data_o(rs2_data)
  );

  decode_stage u_decode (
    .clk_i(clk_i), .reset_i(reset_i), .stall_i(id_stall), .flush_i(ex_flush),
    .instr_i(id_instr), .pc_i(id_pc), .valid_i(id_valid),
    .rs1_data_i(rs1_data), .rs2_data_i(rs2_data),
    .forward_a_i(id_forward_a), .forward_b_i(id_forward_b), .wb_data_i(wb_result),
    .id_rs1_addr_o(id_rs1_addr), .id_rs2_addr_o(id_rs2_addr), .id_trap_o(id_trap),
    .ex_pc_o(ex_pc), .ex_rs1_addr_o(ex_rs1_addr), .ex_rs2_addr_o(ex_rs2_addr),
    .ex_rd_addr_o(ex_rd_addr), .ex_op_a_o(ex_op_a), .ex_op_b_o(ex_op_b), .ex_imm_o(ex_imm),
    .ex_alu_imm_o(ex_alu_imm), .ex_result_src_o(ex_result_src),
    .ex_reg_write_o(ex_reg_write), .ex_mem_write_o(ex_mem_write),
    .ex_branch_o(ex_branch), .ex_trap_o(ex_trap), .ex_valid_o(ex_valid)
  );

  execute_stage u_execute (
    .clk_i(clk_i), .reset_i(reset_i), .flush_i(mem1_flush),
    .ex_pc_i(ex_pc), .ex_rd_addr_i(ex_rd_addr), .ex_op_a_i(ex_op_a), .ex_op_b_i(ex_op_b),
    .ex_imm_i(ex_imm), .ex_alu_imm_i(ex_alu_imm), .ex_result_src_i(ex_result_src),
    .ex_reg_write_i(ex_reg_write), .ex_mem_write_i(ex_mem_write),
    .ex_branch_i(ex_branch), .ex_trap_i(ex_trap), .ex_valid_i(ex_valid),
    .forward_a_i(ex_forward_a), .forward_b_i(ex_forward_b),
    .mem1_result_i(mem1_result), .mem2_result_i(mem2_result), .wb_result_i(wb_result),
    .pc_src_o(pc_src), .branch_target_o(branch_target),
    .mem1_pc_o(mem1_pc), .mem1_alu_o(mem1_alu), .mem1_store_data_o(mem1_store_data),
    .mem1_rd_addr_o(mem1_rd_addr), .mem1_result_src_o(mem1_result_src),
    .mem1_reg_write_o(mem1_reg_write), .mem1_mem_write_o(mem1_mem_write),
    .mem1_trap_o(mem1_trap), .mem1_valid_o(mem1_valid)
  );

  memory_writeback u_memwb (
    .clk_i(clk_i), .reset_i(reset_i),
    .mem1_flush_i(mem1_flush), .mem2_flush_i(mem2_flush), .wb_flush_i(wb_flush),
    .mem1_pc_i(mem1_pc), .mem1_alu_i(mem1_alu), .mem1_store_data_i(mem1_store_data),
    .mem1_rd_addr_i(mem1_rd_addr), .mem1_result_src_i(mem1_result_src),
    .mem1_reg_write_i(mem1_reg_write), .mem1_mem_write_i(mem1_mem_write),
    .mem1_trap_i(mem1_trap), .mem1_valid_i(mem1_valid), .dmem_rdata_i(dmem_rdata_i),
    .dmem_addr_o(dmem_addr_o), .dmem_wdata_o(dmem_wdata_o), .dmem_we_o(dmem_we_o),
    .mem1_result_o(mem1_result), .mem2_result_o(mem2_result),
    .mem2_rd_addr_o(mem2_rd_addr), .wb_result_o(wb_result), .wb_rd_addr_o(wb_rd_addr),
    .mem2_trap_o(mem2_trap), .wb_trap_o(wb_trap), .wb_reg_write_o(wb_reg_write),
    .retire_valid_o(retire_valid_o), .retire_pc_o(retire_pc_o),
    .retire_trap_o(retire_trap_o), .retire_rd_o(retire_rd_o), .retire_data_o(retire_data_o)
  );

  hazard_unit u_hazard (
    .ex_rs1_addr_i(ex_rs1_addr), .ex_rs2_addr_i(ex_rs2_addr),
    .mem1_rd_addr_i(mem1_rd_addr), .mem2_rd_addr_i(mem2_rd_addr), .wb_rd_addr_i(wb_rd_addr),
    .id_rs1_addr_i(id_rs1_addr), .id_rs2_addr_i(id_rs2_addr), .ex_rd_addr_i(ex_rd_addr),
    .ex_result_src_i(ex_result_src), .ex_pc_src_i(pc_src),
    .id_trap_valid_i(id_trap), .ex_trap_valid_i(ex_trap), .mem1_trap_valid_i(mem1_trap),
    .mem2_trap_valid_i(mem2_trap), .wb_trap_valid_i(wb_trap),
    .ex_forward_a_o(ex_forward_a), .ex_forward_b_o(ex_forward_b),
    .id_forward_a_o(id_forward_a), .id_forward_b_o(id_forward_b),
    .id_flush_o(id_flush), .ex_flush_o(ex_flush), .mem1_flush_o(mem1_flush),
    .mem2_flush_o(mem2_flush), .wb_flush_o(wb_flush),
    .if_stall_o(if_stall), .id_stall_o(id_stall)
  );

endmodule

`default_nettype wire

//--- test/tb_program.svh
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

// Draw a value in 0 .. n-1 from the seeded generator
function automatic int urand(input int n);
  return int'($unsigned($random(seed)) % n);
endfunction

function automatic logic [31:0] dmem_fill(input int idx);
  return 32'h5a00_0000 ^ (32'(idx) * 32'h0001_0203);
endfunction

// Kind 0 ADD, 1 ADDI, 2 LW, 3 SW, 4 BEQ
function automatic logic [31:0] encode(input int kind, input logic [4:0] rd,
                                       input logic [4:0] rs1, input logic [4:0] rs2,
                                       input logic [12:0] imm);
  case (kind)
    0: encode = {7'b0, rs2, rs1, 3'b000, rd, 7'b0110011};
    1: encode = {imm[11:0], rs1, 3'b000, rd, 7'b0010011};
    2: encode = {imm[11:0], 5'd0, 3'b010, rd, 7'b0000011};  // Base is always x0
    3: encode = {imm[11:5], rs2, 5'd0, 3'b010, imm[4:0], 7'b0100011};
    default: encode = {imm[12], imm[10:5], rs2, rs1, 3'b000, imm[4:1], imm[11], 7'b1100011};
  endcase
endfunction

task automatic fill_region(input int base, input int words, input bit with_illegal);
  logic [4:0]  rd;
  logic [4:0]  rs1;
  logic [4:0]  rs2;
  logic [12:0] imm;
  logic [31:0] raw;
  int          kind;
  for (int i = 0; i < words - 1; i++) begin
    rd  = 5'(1 + urand(7));  // Destinations x1..x7
    rs1 = 5'(urand(8));
    rs2 = 5'(urand(8));
    raw = $random(seed);
    kind = urand(5);
    case (kind)
      0: imm = 13'd0;
      1: imm = 13'(urand(512)) - 13'd256;
      2, 3: imm = 13'(4 * urand(DMEM_WORDS));
      default: imm = 13'(4 * (1 + urand(words - 1 - i)));  // Forward target inside the region
    endcase
    if (with_illegal && urand(20) == 0) imem[base + i] = {raw[31:7], 7'b0110111};
    else imem[base + i] = encode(kind, rd, rs1, rs2, imm);
  end
  imem[base + words - 1] = encode(4, 5'd0, 5'd0, 5'd0, 13'd0);  // Branch to itself
endtask

// Instruction-level reference model stepping one instruction at a time
task automatic run_model(input int steps);
  logic [31:0] regs [0:31];
  logic [31:0] mem [0:DMEM_WORDS-1];
  logic [31:0] pc, w, a, b, addr, imm_i, imm_s, imm_b;
  logic [6:0]  opc;
  logic [2:0]  f3;
  for (int i = 0; i < 32; i++) regs[i] = '0;
  for (int i = 0; i < DMEM_WORDS; i++) mem[i] = dmem_fill(i);
  pc = core_pkg::RESET_PC;
  for (int n = 0; n < steps; n++) begin
    w     = imem[pc[9:2]];
    opc   = w[6:0];
    f3    = w[14:12];
    a     = regs[w[19:15]];
    b     = regs[w[24:20]];
    imm_i = {{20{w[31]}}, w[31:20]};
    imm_s = {{20{w[31]}}, w[31:25], w[11:7]};
    imm_b = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
    exp_pc[n]   = pc;
    exp_trap[n] = 1'b0;
    exp_rd[n]   = '0;
    exp_data[n] = '0;
    if (opc == 7'b0110011 && f3 == 3'b000 && w[31:25] == 7'd0) begin
      exp_rd[n] = w[11:7];
      exp_data[n] = a + b;
      pc = pc + 32'd4;
    end else if (opc == 7'b0010011 && f3 == 3'b000) begin
      exp_rd[n] = w[11:7];
      exp_data[n] = a + imm_i;
      pc = pc + 32'd4;
    end else if (opc == 7'b0000011 && f3 == 3'b010) begin
      addr = a + imm_i;
      exp_rd[n] = w[11:7];
      exp_data[n] = mem[addr[7:2]];
      pc = pc + 32'd4;
    end else if (opc == 7'b0100011 && f3 == 3'b010) begin
      addr = a + imm_s;
      mem[addr[7:2]] = b;
      exp_st_addr.push_back(addr);
      exp_st_data.push_back(b);
      pc = pc + 32'd4;
    end else if (opc == 7'b1100011 && f3 == 3'b000) begin
      pc = (a == b) ? pc + imm_b : pc + 32'd4;
    end else begin
      exp_trap[n] = 1'b1;  // Illegal word writes nothing
      pc = core_pkg::TRAP_VECTOR;
    end
    if (exp_rd[n] != 5'd0) regs[exp_rd[n]] = exp_data[n];
  end
endtask

`endif

//--- test/tb_pipeline_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_pipeline_core;

  localparam int PROG_WORDS     = 64;
  localparam int HANDLER_WORDS  = 32;
  localparam int DMEM_WORDS     = 64;
  localparam int RETIRE_COUNT   = 300;
  localparam int MODEL_LEN      = RETIRE_COUNT + 40;  // Covers stores already past MEM1
  localparam int TIMEOUT_CYCLES = RETIRE_COUNT * 8;
  localparam int TRAP_IDX       = core_pkg::TRAP_VECTOR >> 2;

  logic        clk_i;
  logic        reset_i;
  logic [31:0] imem_addr_o, imem_data_i;
  logic [31:0] dmem_addr_o, dmem_wdata_o, dmem_rdata_i;
  logic        dmem_we_o;
  logic        retire_valid_o, retire_trap_o;
  logic [31:0] retire_pc_o, retire_data_o;
  logic [4:0]  retire_rd_o;

  int          seed;
  logic [31:0] imem [0:255];
  logic [31:0] dmem [0:DMEM_WORDS-1];
  logic [31:0] exp_pc [0:MODEL_LEN-1];
  logic [4:0]  exp_rd [0:MODEL_LEN-1];
  logic [31:0] exp_data [0:MODEL_LEN-1];
  logic        exp_trap [0:MODEL_LEN-1];
  logic [31:0] exp_st_addr [$];
  logic [31:0] exp_st_data [$];
  int          retire_count;
  int          store_count;
  int          cycle_count;
  logic        trap_retired;

  `include "tb_program.svh"

  pipeline_core i_pipeline_core (
    .clk_i(clk_i), .reset_i(reset_i),
    .imem_addr_o(imem_addr_o), .imem_data_i(imem_data_i),
    .dmem_addr_o(dmem_addr_o), .dmem_wdata_o(dmem_wdata_o), .dmem_we_o(dmem_we_o),
    .dmem_rdata_i(dmem_rdata_i),
    .retire_valid_o(retire_valid_o), .retire_pc_o(retire_pc_o),
    .retire_trap_o(retire_trap_o), .retire_rd_o(retire_rd_o), .retire_data_o(retire_data_o)
  );

  // Both memories answer in the same cycle
  assign imem_data_i  = imem[imem_addr_o[9:2]];
  assign dmem_rdata_i = dmem[dmem_addr_o[7:2]];

  always @(posedge clk_i) begin
    if (dmem_we_o === 1'b1) dmem[dmem_addr_o[7:2]] <= dmem_wdata_o;
  end

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  task automatic stop_on_failure();
    $display("SIMULATION FAILED");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp) else begin
      $display("ERROR %s got 0x%08h expected 0x%08h", name, got, exp);
      stop_on_failure();
    end
  endtask

  always @(posedge clk_i) begin
    cycle_count <= cycle_count + 1;
  end

  always @(posedge clk_i) begin
    if (reset_i === 1'b1 && cycle_count > 0) begin
      assert (retire_valid_o === 1'b0 && dmem_we_o === 1'b0) else begin
        $display("Retire or store activity seen while reset was asserted");
        stop_on_failure();
      end
      check_value("imem_addr_o", imem_addr_o, core_pkg::RESET_PC);
    end
  end

  // Retire stream checked against the model in program order
  always @(posedge clk_i) begin
    if (reset_i === 1'b0 && retire_valid_o === 1'b1 && retire_count < MODEL_LEN) begin
      check_value("retire_pc_o", retire_pc_o, exp_pc[retire_count]);
      check_value("retire_trap_o", {31'd0, retire_trap_o}, {31'd0, exp_trap[retire_count]});
      check_value("retire_rd_o", {27'd0, retire_rd_o}, {27'd0, exp_rd[retire_count]});
      check_value("retire_data_o", retire_data_o, exp_data[retire_count]);
      retire_count <= retire_count + 1;
    end
  end

  // Fetch restarts at the trap vector in the cycle after a trap retires
  always @(posedge clk_i) begin
    if (trap_retired === 1'b1) begin
      check_value("imem_addr_o", imem_addr_o, core_pkg::TRAP_VECTOR);
    end
    trap_retired <= (reset_i === 1'b0) && (retire_valid_o === 1'b1) &&
                    (retire_trap_o === 1'b1);
  end

  always @(posedge clk_i) begin
    if (reset_i === 1'b0 && dmem_we_o === 1'b1) begin
      assert (store_count < exp_st_addr.size()) else begin
        $display("Store seen that the reference model never performs");
        stop_on_failure();
      end
      check_value("dmem_addr_o", dmem_addr_o, exp_st_addr[store_count]);
      check_value("dmem_wdata_o", dmem_wdata_o, exp_st_data[store_count]);
      store_count <= store_count + 1;
    end
  end

  initial begin
    reset_i <= 1'b1;
    seed    = 32'h421c;
    for (int i = 0; i < 256; i++) imem[i] = encode(1, 5'd0, 5'd0, 5'd0, 13'(i));
    for (int i = 0; i < DMEM_WORDS; i++) dmem[i] <= dmem_fill(i);
    fill_region(0, PROG_WORDS, 1'b1);
    fill_region(TRAP_IDX, HANDLER_WORDS, 1'b0);  // Handler has no illegal words
    run_model(MODEL_LEN);
    repeat (4) @(posedge clk_i);
    reset_i <= 1'b0;
    while (retire_count < RETIRE_COUNT && cycle_count < TIMEOUT_CYCLES) @(posedge clk_i);
    if (retire_count >= RETIRE_COUNT) begin
      $display("SIMULATION PASSED");
      $finish;
    end else begin
      $display("Timeout after %0d cycles with only %0d of %0d instructions retired",
               cycle_count, retire_count, RETIRE_COUNT);
      stop_on_failure();
    end
  end

endmodule

`default_nettype wire

//--- pipeline_core.f
+incdir+test
rtl/core_pkg.sv
rtl/hazard_unit.sv
rtl/fetch_stage.sv
rtl/reg_file.sv
rtl/decode_stage.sv
rtl/execute_stage.sv
rtl/memory_writeback.sv
rtl/pipeline_core.sv
test/tb_pipeline_core.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Compile and run the pipeline_core testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module tb_pipeline_core \
  -f pipeline_core.f \
  -o tb_sim

# The simulator exit status is masked by tee, the log decides
./obj_dir/tb_sim | tee sim.log

if grep -q "SIMULATION PASSED" sim.log; then
  echo "Run result: pass"
  exit 0
else
  echo "Run result: fail"
  exit 1
fi
